// ==== Bender.yml ====
package:
  name: play_chart

sources:
  - include_dirs:
      - include
    files:
      - src/note_pkg.sv
      - src/display_pkg.sv
      - src/step_timer.sv
      - src/note_feed.sv
      - src/timing_judge.sv
      - src/result_out.sv
      - src/play_chart_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/play_chart_chk.sv
      - tb/play_chart_tb.sv

// ==== include/play_defines.svh ====
`ifndef PLAY_DEFINES_SVH
`define PLAY_DEFINES_SVH

// Note word layout
`define NOTE_W 9
`define KEY_W 7

// Step length in prog_clk cycles, shortened for simulation
`define STEP_CYCLES 8

// Steps per countdown digit
`define DIGIT_STEPS 2

// Earlier steps kept for late hits
`define HIST_DEPTH 3

// Points per judgement
`define PTS_PERFECT 4
`define PTS_GOOD 2
`define PTS_LATE 1

// Running score width
`define SCORE_W 14

`endif

// ==== project.f ====
+incdir+include
src/note_pkg.sv
src/display_pkg.sv
src/step_timer.sv
src/note_feed.sv
src/timing_judge.sv
src/result_out.sv
src/play_chart_top.sv
tb/play_chart_chk.sv
tb/play_chart_tb.sv

// ==== src/display_pkg.sv ====
package display_pkg;

    // Bit 0 octave lamp, bits 7..1 key lamps with C on bit 7
    typedef logic [7:0] led_pattern_t;

    // Octave mark shown next to the digit
    typedef enum logic [1:0] {
        OCT_NONE,
        OCT_UP,
        OCT_DOWN
    } seg_oct_e;

    // Digit 1..7 for C..B, 0 blanks the display
    typedef struct packed {
        seg_oct_e   octave;
        logic [3:0] digit;
    } seg_code_t;

endpackage

// ==== src/note_feed.sv ====
`timescale 1ns/100ps

module note_feed (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 step,
    input  logic                 auto_play,
    input  logic                 chart_valid,
    input  note_pkg::note_word_u chart_note,
    input  logic                 chart_last,
    input  note_pkg::note_word_u keys,
    output logic                 chart_ready,
    output logic                 cur_valid,
    output note_pkg::note_word_u cur_note,
    output note_pkg::note_word_u cur_keys,
    output logic                 cur_last
);
    logic chart_ended;

    // One note per step, none after the last one
    assign chart_ready = step & ~chart_ended;
    assign cur_valid   = chart_ready & chart_valid;

    // Data is taken by the judge register on the transfer edge
    assign cur_note = chart_note;
    assign cur_last = chart_last;

    // Auto-play presses exactly what the chart asks for
    always_comb begin
        if (auto_play) begin
            cur_keys = chart_note;
        end else begin
            cur_keys = keys;
        end
    end

    // Chart end tracking
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            chart_ended <= 1'b0;
        end else if (cur_valid && chart_last) begin
            chart_ended <= 1'b1;
        end
    end

endmodule

// ==== src/note_pkg.sv ====
`include "play_defines.svh"

package note_pkg;

    // One note as the player sees it, C is keys[0]
    typedef struct packed {
        logic              oct_down;
        logic              oct_up;
        logic [`KEY_W-1:0] keys;
    } note_fields_t;

    // Judge compares raw words, display side decodes the fields
    typedef union packed {
        logic [`NOTE_W-1:0] raw;
        note_fields_t       fields;
    } note_word_u;

    // Timing grade of one step
    typedef enum logic [1:0] {
        MISS,
        LATE,
        GOOD,
        PERFECT
    } judge_e;

endpackage

// ==== src/play_chart_top.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module play_chart_top (
    input  logic                      prog_clk,
    input  logic                      rst,
    input  logic                      auto_play,
    input  note_pkg::note_word_u      keys,
    input  logic                      chart_valid,
    output logic                      chart_ready,
    input  note_pkg::note_word_u      chart_note,
    input  logic                      chart_last,
    output logic                      result_valid,
    input  logic                      result_ready,
    output note_pkg::note_word_u      result_note,
    output display_pkg::led_pattern_t result_led,
    output display_pkg::seg_code_t    result_seg,
    output logic [`SCORE_W-1:0]       result_score,
    output logic                      result_last,
    output logic [1:0]                count_digit,
    output logic                      playing
);
    logic                 step;
    logic                 slot_free;
    logic                 done;
    logic                 cur_valid;
    logic                 cur_last;
    note_pkg::note_word_u cur_note;
    note_pkg::note_word_u cur_keys;
    logic                 judged_valid;
    logic                 judged_last;
    note_pkg::note_word_u judged_note;
    logic [`SCORE_W-1:0]  judged_score;

    step_timer u_step_timer (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .slot_free   (slot_free),
        .done        (done),
        .step        (step),
        .count_digit (count_digit),
        .playing     (playing)
    );

    note_feed u_note_feed (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .step        (step),
        .auto_play   (auto_play),
        .chart_valid (chart_valid),
        .chart_note  (chart_note),
        .chart_last  (chart_last),
        .keys        (keys),
        .chart_ready (chart_ready),
        .cur_valid   (cur_valid),
        .cur_note    (cur_note),
        .cur_keys    (cur_keys),
        .cur_last    (cur_last)
    );

    timing_judge u_timing_judge (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .cur_valid    (cur_valid),
        .cur_last     (cur_last),
        .cur_note     (cur_note),
        .cur_keys     (cur_keys),
        .judged_valid (judged_valid),
        .judged_last  (judged_last),
        .judged_note  (judged_note),
        .judged_score (judged_score)
    );

    result_out u_result_out (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .judged_valid (judged_valid),
        .judged_last  (judged_last),
        .judged_note  (judged_note),
        .judged_score (judged_score),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_note  (result_note),
        .result_led   (result_led),
        .result_seg   (result_seg),
        .result_score (result_score),
        .result_last  (result_last),
        .slot_free    (slot_free),
        .done         (done)
    );

endmodule

// ==== src/result_out.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module result_out (
    input  logic                      prog_clk,
    input  logic                      rst,
    input  logic                      judged_valid,
    input  logic                      judged_last,
    input  note_pkg::note_word_u      judged_note,
    input  logic [`SCORE_W-1:0]       judged_score,
    input  logic                      result_ready,
    output logic                      result_valid,
    output note_pkg::note_word_u      result_note,
    output display_pkg::led_pattern_t result_led,
    output display_pkg::seg_code_t    result_seg,
    output logic [`SCORE_W-1:0]       result_score,
    output logic                      result_last,
    output logic                      slot_free,
    output logic                      done
);
    display_pkg::led_pattern_t led_next;
    display_pkg::seg_code_t    seg_next;
    logic                      one_key;
    logic                      oct_ok;

    assign one_key = $onehot(judged_note.fields.keys);
    assign oct_ok  = ~(judged_note.fields.oct_up & judged_note.fields.oct_down);

    // LED lamps, key order reversed so C lands on bit 7
    always_comb begin
        led_next    = '0;
        led_next[0] = judged_note.fields.oct_up | judged_note.fields.oct_down;
        if (one_key) begin
            for (int i = 0; i < `KEY_W; i++) begin
                led_next[7-i] = judged_note.fields.keys[i];
            end
        end
    end

    // Segment code, whole display blank for chords and rests
    always_comb begin
        seg_next = '0;
        if (one_key && oct_ok) begin
            for (int i = 0; i < `KEY_W; i++) begin
                if (judged_note.fields.keys[i]) begin
                    seg_next.digit = 4'(i + 1);
                end
            end
            if (judged_note.fields.oct_up) begin
                seg_next.octave = display_pkg::OCT_UP;
            end else if (judged_note.fields.oct_down) begin
                seg_next.octave = display_pkg::OCT_DOWN;
            end
        end
    end

    // One result slot, only loaded while empty
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (judged_valid) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (judged_valid) begin
            result_note  <= judged_note;
            result_led   <= led_next;
            result_seg   <= seg_next;
            result_score <= judged_score;
            result_last  <= judged_last;
        end
    end

    // Room for a new step only with nothing held and nothing on the way
    assign slot_free = ~(result_valid | judged_valid);
    assign done      = result_valid & result_ready & result_last;

endmodule

// ==== src/step_timer.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module step_timer (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       slot_free,
    input  logic       done,
    output logic       step,
    output logic [1:0] count_digit,
    output logic       playing
);
    localparam int PRE_W = $clog2(`STEP_CYCLES);
    localparam int DIG_W = $clog2(`DIGIT_STEPS + 1);

    logic [PRE_W-1:0] pre_cnt;
    logic [DIG_W-1:0] dig_cnt;
    logic             tick;
    logic             pending;
    logic             finished;

    // Free running step prescaler
    assign tick = (pre_cnt == PRE_W'(`STEP_CYCLES - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // A due step waits until the output side has room
    assign step = playing & slot_free & (tick | pending);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            dig_cnt     <= '0;
            count_digit <= 2'd3;
            playing     <= 1'b0;
            finished    <= 1'b0;
            pending     <= 1'b0;
        end else if (playing) begin
            if (done) begin
                playing  <= 1'b0;
                finished <= 1'b1;
                pending  <= 1'b0;
            end else begin
                pending <= (pending | tick) & ~slot_free;
            end
        end else if (!finished && tick) begin
            // Countdown 3, 2, 1, 0, then play
            if (dig_cnt == DIG_W'(`DIGIT_STEPS - 1)) begin
                dig_cnt <= '0;
                if (count_digit == 2'd0) begin
                    playing <= 1'b1;
                end else begin
                    count_digit <= count_digit - 2'd1;
                end
            end else begin
                dig_cnt <= dig_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== src/timing_judge.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module timing_judge (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 cur_valid,
    input  logic                 cur_last,
    input  note_pkg::note_word_u cur_note,
    input  note_pkg::note_word_u cur_keys,
    output logic                 judged_valid,
    output logic                 judged_last,
    output note_pkg::note_word_u judged_note,
    output logic [`SCORE_W-1:0]  judged_score
);
    // hist[0] is one step back
    note_pkg::note_word_u hist [`HIST_DEPTH];
    note_pkg::judge_e     grade;
    logic [`SCORE_W-1:0]  points;

    // First matching rule wins, rests never score
    always_comb begin
        if (cur_note.raw == '0) begin
            grade = note_pkg::MISS;
        end else if (cur_note.raw == cur_keys.raw || cur_note.raw == hist[0].raw) begin
            grade = note_pkg::PERFECT;
        end else if (cur_note.raw == hist[1].raw) begin
            grade = note_pkg::GOOD;
        end else if (cur_note.raw == hist[2].raw) begin
            grade = note_pkg::LATE;
        end else begin
            grade = note_pkg::MISS;
        end
    end

    always_comb begin
        case (grade)
            note_pkg::PERFECT: points = `SCORE_W'(`PTS_PERFECT);
            note_pkg::GOOD:    points = `SCORE_W'(`PTS_GOOD);
            note_pkg::LATE:    points = `SCORE_W'(`PTS_LATE);
            default:           points = '0;
        endcase
    end

    // Key history and running score
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                hist[i] <= '0;
            end
            judged_valid <= 1'b0;
            judged_score <= '0;
        end else begin
            judged_valid <= cur_valid;
            if (cur_valid) begin
                hist[0] <= cur_keys;
                for (int i = 1; i < `HIST_DEPTH; i++) begin
                    hist[i] <= hist[i-1];
                end
                judged_score <= judged_score + points;
            end
        end
    end

    // Played note and end flag ride along with the score
    always_ff @(posedge prog_clk) begin
        if (cur_valid) begin
            judged_note <= cur_keys;
            judged_last <= cur_last;
        end
    end

endmodule

// ==== tb/play_chart_chk.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module play_chart_chk (
    input logic                prog_clk,
    input logic                rst,
    input logic                chart_valid,
    input logic                chart_ready,
    input logic                slot_free,
    input logic                playing,
    input logic                result_valid,
    input logic                result_ready,
    input logic [`NOTE_W-1:0]  result_note,
    input logic [7:0]          result_led,
    input logic [5:0]          result_seg,
    input logic [`SCORE_W-1:0] result_score,
    input logic                result_last
);
    int fail_count = 0;

    // Held result must not move until taken
    result_held: assert property (@(posedge prog_clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid &&
            $stable({result_note, result_led, result_seg, result_score, result_last}))
    else begin
        fail_count++;
        $error("result data changed before the handshake");
    end

    ready_in_play: assert property (@(posedge prog_clk) disable iff (rst)
        chart_ready |-> playing)
    else begin
        fail_count++;
        $error("chart_ready high outside play");
    end

    // Judge register, then output register
    result_latency: assert property (@(posedge prog_clk) disable iff (rst)
        chart_valid && chart_ready && slot_free |-> ##1 !result_valid ##1 result_valid)
    else begin
        fail_count++;
        $error("result_valid not two cycles after the consumed step");
    end

endmodule

bind play_chart_top play_chart_chk chk0 (
    .prog_clk     (prog_clk),
    .rst          (rst),
    .chart_valid  (chart_valid),
    .chart_ready  (chart_ready),
    .slot_free    (slot_free),
    .playing      (playing),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_note  (result_note),
    .result_led   (result_led),
    .result_seg   (result_seg),
    .result_score (result_score),
    .result_last  (result_last)
);

// ==== tb/play_chart_tb.sv ====
`timescale 1ns/100ps
`include "play_defines.svh"

module play_chart_tb;

    localparam int NUM_ROWS = 18;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 4 * `DIGIT_STEPS) * `STEP_CYCLES * 4;

    // One table row: chart note, keys, auto-play, random ready, last
    typedef struct packed {
        logic [`NOTE_W-1:0] note;
        logic [`NOTE_W-1:0] keys;
        logic               auto_mode;
        logic               stall;
        logic               last;
    } row_t;

    logic                      prog_clk;
    logic                      rst;
    logic                      auto_play;
    note_pkg::note_word_u      keys;
    logic                      chart_valid;
    logic                      chart_ready;
    note_pkg::note_word_u      chart_note;
    logic                      chart_last;
    logic                      result_valid;
    logic                      result_ready;
    note_pkg::note_word_u      result_note;
    display_pkg::led_pattern_t result_led;
    display_pkg::seg_code_t    result_seg;
    logic [`SCORE_W-1:0]       result_score;
    logic                      result_last;
    logic [1:0]                count_digit;
    logic                      playing;

    row_t                rows [NUM_ROWS];
    logic [`NOTE_W-1:0]  played_hist [`HIST_DEPTH];
    logic [`SCORE_W-1:0] exp_score;
    logic [31:0]         lcg_state;
    int                  check_count;
    int                  error_count;
    int                  cycle_count;

    play_chart_top dut0 (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .auto_play    (auto_play),
        .keys         (keys),
        .chart_valid  (chart_valid),
        .chart_ready  (chart_ready),
        .chart_note   (chart_note),
        .chart_last   (chart_last),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_note  (result_note),
        .result_led   (result_led),
        .result_seg   (result_seg),
        .result_score (result_score),
        .result_last  (result_last),
        .count_digit  (count_digit),
        .playing      (playing)
    );

    initial prog_clk = 1'b0;
    always #50 prog_clk = ~prog_clk;

    // Run limit scaled to countdown plus table length
    always @(posedge prog_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("checks=%0d errors=%0d", check_count, error_count + 1);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int key_index(input logic [`KEY_W-1:0] k);
        int idx;
        idx = 0;
        for (int i = 0; i < `KEY_W; i++) begin
            if (k[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Points from the history rules, first match wins
    function automatic int points_for(input logic [`NOTE_W-1:0] note,
                                      input logic [`NOTE_W-1:0] played);
        if (note == '0) begin
            return 0;
        end
        if (note == played || note == played_hist[0]) begin
            return `PTS_PERFECT;
        end
        if (note == played_hist[1]) begin
            return `PTS_GOOD;
        end
        if (note == played_hist[2]) begin
            return `PTS_LATE;
        end
        return 0;
    endfunction

    function automatic logic [7:0] led_for(input logic [`NOTE_W-1:0] n);
        logic [7:0] led;
        led = {7'd0, n[7] | n[8]};
        if ($countones(n[`KEY_W-1:0]) == 1) begin
            led = led | (8'h80 >> key_index(n[`KEY_W-1:0]));
        end
        return led;
    endfunction

    // Octave mark in the top two bits, digit below
    function automatic logic [5:0] seg_for(input logic [`NOTE_W-1:0] n);
        logic [1:0] oct;
        logic [3:0] digit;
        oct = 2'd0;
        digit = 4'd0;
        if ($countones(n[`KEY_W-1:0]) == 1 && !(n[7] && n[8])) begin
            digit = 4'(key_index(n[`KEY_W-1:0]) + 1);
            oct = n[7] ? 2'd1 : (n[8] ? 2'd2 : 2'd0);
        end
        return {oct, digit};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic load_table();
        // Timing judgement, in order: now, one, two and three steps back
        rows[0]  = {9'h001, 9'h001, 1'b0, 1'b0, 1'b0};
        rows[1]  = {9'h002, 9'h004, 1'b0, 1'b0, 1'b0};
        rows[2]  = {9'h004, 9'h008, 1'b0, 1'b0, 1'b0};
        rows[3]  = {9'h004, 9'h010, 1'b0, 1'b0, 1'b0};
        rows[4]  = {9'h004, 9'h020, 1'b0, 1'b0, 1'b0};
        // Rest, chord, octave up, octave down, both octave bits
        rows[5]  = {9'h000, 9'h000, 1'b0, 1'b0, 1'b0};
        rows[6]  = {9'h015, 9'h015, 1'b0, 1'b0, 1'b0};
        rows[7]  = {9'h090, 9'h090, 1'b0, 1'b0, 1'b0};
        rows[8]  = {9'h140, 9'h140, 1'b0, 1'b0, 1'b0};
        rows[9]  = {9'h181, 9'h181, 1'b0, 1'b0, 1'b0};
        // Auto-play ignores the keys
        rows[10] = {9'h002, 9'h040, 1'b1, 1'b0, 1'b0};
        rows[11] = {9'h000, 9'h001, 1'b1, 1'b0, 1'b0};
        rows[12] = {9'h088, 9'h000, 1'b1, 1'b0, 1'b0};
        // Random back-pressure up to the last note
        rows[13] = {9'h020, 9'h020, 1'b0, 1'b1, 1'b0};
        rows[14] = {9'h040, 9'h000, 1'b0, 1'b1, 1'b0};
        rows[15] = {9'h020, 9'h001, 1'b0, 1'b1, 1'b0};
        rows[16] = {9'h081, 9'h081, 1'b0, 1'b1, 1'b0};
        rows[17] = {9'h002, 9'h002, 1'b0, 1'b1, 1'b1};
    endtask

    task automatic watch_countdown();
        logic [1:0] last_digit;
        int         span;
        last_digit = 2'd3;
        span = 0;
        while (!playing) begin
            @(negedge prog_clk);
            if (!playing) begin
                require_true(!chart_ready, "chart_ready high during the countdown");
                if (count_digit != last_digit) begin
                    compare_value("count_digit", count_digit, last_digit - 2'd1);
                    if (last_digit != 2'd3) begin
                        compare_value("digit length", span, `DIGIT_STEPS * `STEP_CYCLES);
                    end
                    last_digit = count_digit;
                    span = 1;
                end else begin
                    span++;
                end
            end
        end
        compare_value("count_digit", last_digit, 0);
        compare_value("digit length", span, `DIGIT_STEPS * `STEP_CYCLES);
    endtask

    task automatic run_row(input int r);
        logic [`NOTE_W-1:0] played;
        int                 pts;
        logic               waiting;
        @(negedge prog_clk);
        chart_note.raw = rows[r].note;
        chart_last = rows[r].last;
        auto_play = rows[r].auto_mode;
        keys.raw = rows[r].keys;
        chart_valid = 1'b1;
        result_ready = !rows[r].stall;
        waiting = 1'b1;
        while (waiting) begin
            require_true(playing, "playing low while chart notes remain");
            require_true(!result_valid, "result appeared without a chart note");
            if (chart_ready) begin
                waiting = 1'b0;
            end else begin
                @(negedge prog_clk);
            end
        end
        played = rows[r].auto_mode ? rows[r].note : rows[r].keys;
        pts = points_for(rows[r].note, played);
        exp_score = exp_score + `SCORE_W'(pts);
        for (int i = `HIST_DEPTH - 1; i > 0; i--) begin
            played_hist[i] = played_hist[i-1];
        end
        played_hist[0] = played;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge prog_clk);
            chart_valid = 1'b0;
            if (rows[r].stall) begin
                lcg_state = lcg_next(lcg_state);
                result_ready = lcg_state[16];
            end else begin
                result_ready = 1'b1;
            end
            if (result_valid && result_ready) begin
                compare_value("result_note", result_note.raw, played);
                compare_value("result_led", result_led, led_for(played));
                compare_value("result_seg", result_seg, seg_for(played));
                compare_value("result_score", result_score, exp_score);
                compare_value("result_last", result_last, rows[r].last);
                waiting = 1'b0;
            end
        end
    endtask

    // Chart is over, offered notes must be refused
    task automatic verify_idle_end();
        @(negedge prog_clk);
        compare_value("playing", playing, 0);
        chart_valid = 1'b1;
        chart_note.raw = 9'h001;
        chart_last = 1'b0;
        result_ready = 1'b1;
        repeat (4 * `STEP_CYCLES) begin
            @(negedge prog_clk);
            require_true(!chart_ready && !result_valid && !playing,
                         "activity after the last result");
        end
        chart_valid = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        auto_play = 1'b0;
        keys = '0;
        chart_valid = 1'b0;
        chart_note = '0;
        chart_last = 1'b0;
        result_ready = 1'b0;
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        exp_score = '0;
        lcg_state = 32'hfad4_d4b1;
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            played_hist[i] = '0;
        end
        load_table();
        repeat (4) @(negedge prog_clk);
        rst = 1'b0;
        compare_value("count_digit", count_digit, 3);
        require_true(!playing && !chart_ready && !result_valid, "outputs not idle after reset");
        watch_countdown();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        verify_idle_end();
        error_count = error_count + dut0.chk0.fail_count;
        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
